/* image_cases.txt */
// tag (1 = stream 1, 2 = stream 2), last flag, then words 0 to 5 in hex
// Stream 1 opens each image with a header: is_not_max, is_max, is_lrelu, kernel_h_1
// Max image, kernel 1
1 0 00 01 00 00 00 00
1 0 11 12 13 14 15 16
2 0 a1 a2 a3 a4 a5 a6
1 0 21 22 23 24 25 26
2 0 b1 b2 b3 b4 b5 b6
1 1 31 32 33 34 35 36
2 0 c1 c2 c3 c4 c5 c6
// Shared image, kernel 3, stream 2 already offers the next max image
1 0 01 00 01 02 00 00
1 0 41 42 43 44 45 46
1 0 51 52 53 54 55 56
1 1 61 62 63 64 65 66
// Max image, kernel 3
1 0 00 01 01 02 00 00
2 0 d1 d2 d3 d4 d5 d6
1 0 71 72 73 74 75 76
2 0 e1 e2 e3 e4 e5 e6
1 0 81 82 83 84 85 86
2 0 f1 f2 f3 f4 f5 f6
1 1 91 92 93 94 95 96
// Shared image, kernel 1, one beat
1 0 01 00 00 00 00 00
1 1 0a 0b 0c 0d 0e 0f
// Max image, kernel 3, lrelu
1 0 00 01 01 02 00 00
1 0 c7 c8 c9 ca cb cc
2 0 17 27 37 47 57 67
1 1 d7 d8 d9 da db dc
2 0 18 28 38 48 58 68

/* list.f */
image_pkg.sv
axis_image_pipe.sv
image_shift_buffer.sv
axis_reg_slice.sv
image_stage_top.sv
image_checker.sv
tb_image_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the image stage testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_image_stage -o sim_image_stage
./obj_dir/sim_image_stage | tee sim.log

if grep -qx "Everything OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tb_image_stage.sv */
// Testbench for the image input stage: clock, reset, beats from the case file and the final report
`timescale 1ns/1ps

module tb_image_stage import image_pkg::*; ();

  localparam int MAX_LINES = 64;

  logic       aclk     = 1'b0;
  logic       reset    = 1'b1;
  logic       s1_valid = 1'b0;
  logic       s1_ready;
  in_row_t    s1_data  = '0;
  logic       s1_last  = 1'b0;
  logic       s2_valid = 1'b0;
  logic       s2_ready;
  in_row_t    s2_data  = '0;
  logic       m_ready  = 1'b0;
  logic       m_valid;
  pair_out_t  m_data;
  pipe_user_t m_user;

  logic [7:0] case_mem [0:8*MAX_LINES-1];  // Tag, last, six words per line
  in_row_t    s1_rows[$];
  logic       s1_lasts[$];
  in_row_t    s2_rows[$];
  int         s1_idx = 0;
  int         s2_idx = 0;
  int         n_lines;
  int         cycles = 0;
  int         cycle_limit;
  int         tb_errors = 0;
  int         value_errors;
  int         other_errors;
  int         pending;
  int         seed_dummy;
  logic       running = 1'b0;

  always #4 aclk = ~aclk;

  always @(posedge aclk) cycles <= cycles + 1;

  image_stage_top UUT (
    .aclk     (aclk    ),
    .reset    (reset   ),
    .s1_valid (s1_valid),
    .s1_ready (s1_ready),
    .s1_data  (s1_data ),
    .s1_last  (s1_last ),
    .s2_valid (s2_valid),
    .s2_ready (s2_ready),
    .s2_data  (s2_data ),
    .m_ready  (m_ready ),
    .m_valid  (m_valid ),
    .m_data   (m_data  ),
    .m_user   (m_user  )
  );

  image_checker scoreboard (
    .aclk         (aclk        ),
    .reset        (reset       ),
    .s1_valid     (s1_valid    ),
    .s1_ready     (s1_ready    ),
    .s1_data      (s1_data     ),
    .s1_last      (s1_last     ),
    .s2_valid     (s2_valid    ),
    .s2_ready     (s2_ready    ),
    .s2_data      (s2_data     ),
    .m_valid      (m_valid     ),
    .m_ready      (m_ready     ),
    .m_data       (m_data      ),
    .m_user       (m_user      ),
    .value_errors (value_errors),
    .other_errors (other_errors),
    .pending      (pending     )
  );

  // Splits the case lines into one queue per stream
  task automatic load_cases();
    in_row_t row;
    for (int a = 0; a < 8 * MAX_LINES; a++)
      case_mem[a] = 8'hff;  // Tag ff marks an unused line
    $readmemh("image_cases.txt", case_mem);
    n_lines = 0;
    while (n_lines < MAX_LINES && case_mem[8 * n_lines] != 8'hff) begin
      for (int w = 0; w < UNITS_EDGES; w++)
        row[w] = case_mem[8 * n_lines + 2 + w];
      if (case_mem[8 * n_lines] == 8'h02) begin
        s2_rows.push_back(row);
      end else begin
        s1_rows.push_back(row);
        s1_lasts.push_back(case_mem[8 * n_lines + 1][0]);
      end
      n_lines++;
    end
  endtask

  function automatic logic all_done();
    return s1_idx == s1_rows.size() && !s1_valid && s2_idx == s2_rows.size() && !s2_valid
           && pending == 0 && !m_valid;
  endfunction

  // Each stream holds its beat until taken; gaps and m_ready come from $urandom
  always @(posedge aclk) begin
    if (running) begin
      if (!s1_valid || s1_ready) begin
        if (s1_idx < s1_rows.size() && ($urandom % 4) != 0) begin
          s1_valid <= 1'b1;
          s1_data  <= s1_rows[s1_idx];
          s1_last  <= s1_lasts[s1_idx];
          s1_idx   <= s1_idx + 1;
        end else begin
          s1_valid <= 1'b0;
        end
      end
      if (!s2_valid || s2_ready) begin
        if (s2_idx < s2_rows.size() && ($urandom % 4) != 0) begin
          s2_valid <= 1'b1;
          s2_data  <= s2_rows[s2_idx];
          s2_idx   <= s2_idx + 1;
        end else begin
          s2_valid <= 1'b0;
        end
      end
      m_ready <= ($urandom % 3) != 0;
    end
  end

  initial begin
    seed_dummy = $urandom(32'h9fdd81c3);
    load_cases();
    cycle_limit = 40 * n_lines + 200;
    repeat (3) @(posedge aclk);
    reset   <= 1'b0;
    running <= 1'b1;
    while (!all_done() && cycles < cycle_limit)
      @(negedge aclk);
    if (!all_done()) begin
      $display("Timeout after %0d cycles with %0d expected output beats still missing",
               cycles, pending);
      tb_errors++;
    end else begin
      repeat (20) @(negedge aclk);  // Room for stray output beats
    end
    $display("Errors: %0d wrong values, %0d protocol or order, %0d timeout",
             value_errors, other_errors, tb_errors);
    if (value_errors + other_errors + tb_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* image_checker.sv */
// Image stage checker: follows the beats taken at the inputs, predicts the output beats, counts errors
`timescale 1ns/1ps

module image_checker import image_pkg::*; (
  input  logic       aclk,
  input  logic       reset,
  input  logic       s1_valid,
  input  logic       s1_ready,
  input  in_row_t    s1_data,
  input  logic       s1_last,
  input  logic       s2_valid,
  input  logic       s2_ready,
  input  in_row_t    s2_data,
  input  logic       m_valid,
  input  logic       m_ready,
  input  pair_out_t  m_data,
  input  pipe_user_t m_user,
  output int         value_errors,
  output int         other_errors,
  output int         pending
);

  typedef struct packed {
    pair_out_t  data;
    pipe_user_t user;
  } beat_t;

  beat_t      exp_q[$];
  image_cfg_t cfg;
  in_row_t    ones_row;
  logic       want_header;
  logic       started;
  logic       reset_seen = 1'b0;

  initial begin
    for (int u = 0; u < UNITS_EDGES; u++)
      ones_row[u] = (u <= KERNEL_H_MAX / 2) ? WORD_WIDTH'(1) : '0;  // Ones on the low words
  end

  // Word u of repeat j is de-centered word u+j, zero past the kernel's edge
  function automatic out_row_t expect_row(input in_row_t row, input int k, input int j);
    out_row_t r;
    int       h2;
    int       i;
    r  = '0;
    h2 = k / 2;
    for (int u = 0; u < UNITS; u++) begin
      i = u + j;
      if (i <= UNITS - 1 + 2 * h2 && i < UNITS_EDGES)
        r[u] = row[i + KERNEL_H_MAX / 2 - h2];
    end
    return r;
  endfunction

  task automatic push_beats(input in_row_t r1, input in_row_t r2, input logic is_cfg,
                            input int reps);
    beat_t b;
    for (int j = 0; j < reps; j++) begin
      b.data.ch1      = expect_row(r1, cfg.kernel_h_1, is_cfg ? 0 : j);  // Config beats never shift
      b.data.ch2      = expect_row(r2, cfg.kernel_h_1, is_cfg ? 0 : j);
      b.user.cfg      = cfg;
      b.user.is_config = is_cfg;
      exp_q.push_back(b);
    end
  endtask

  task automatic compare_beat(input beat_t exp);
    if (m_data.ch1 !== exp.data.ch1) begin
      $display("Fail at %0t: m_data.ch1 expected %h, got %h", $time, exp.data.ch1, m_data.ch1);
      value_errors++;
    end
    if (m_data.ch2 !== exp.data.ch2) begin
      $display("Fail at %0t: m_data.ch2 expected %h, got %h", $time, exp.data.ch2, m_data.ch2);
      value_errors++;
    end
    if (m_user !== exp.user) begin
      $display("Fail at %0t: m_user expected %h, got %h", $time, exp.user, m_user);
      value_errors++;
    end
  endtask

  always @(posedge aclk) begin
    if (reset) begin
      if (!reset_seen) begin
        value_errors = 0;
        other_errors = 0;
      end else if (s1_ready || s2_ready || m_valid) begin
        $display("At %0t a ready or m_valid is high while reset is held", $time);
        other_errors++;
      end
      reset_seen  = 1'b1;
      want_header = 1'b1;
      started     = 1'b0;
      exp_q.delete();
    end else begin
      if (!started && (m_valid || s2_ready)) begin
        $display("At %0t m_valid or s2_ready rose before any input beat was taken", $time);
        other_errors++;
      end
      // Stream 2 may only move together with stream 1 inside a max image
      if (s2_valid && s2_ready && (want_header || !cfg.is_max || !(s1_valid && s1_ready))) begin
        $display("At %0t stream 2 gave a beat outside a paired max transfer", $time);
        other_errors++;
      end
      if (s1_valid && s1_ready) begin
        started = 1'b1;
        if (want_header) begin
          cfg.is_not_max = s1_data[I_IS_NOT_MAX][0];
          cfg.is_max     = s1_data[I_IS_MAX][0];
          cfg.is_lrelu   = s1_data[I_IS_LRELU][0];
          cfg.kernel_h_1 = s1_data[I_KERNEL_H_1][BITS_KERNEL_H-1:0];
          want_header    = 1'b0;
          push_beats(ones_row, ones_row, 1'b1, cfg.kernel_h_1 / 2 + 2);
        end else begin
          if (cfg.is_max && !(s2_valid && s2_ready)) begin
            $display("At %0t stream 1 gave a data beat without stream 2 in a max image", $time);
            other_errors++;
          end
          push_beats(s1_data, cfg.is_max ? s2_data : s1_data, 1'b0, cfg.kernel_h_1 + 1);
          want_header = s1_last;  // Next stream 1 beat opens a new image
        end
      end
      if (m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          $display("At %0t an output beat appeared that no input beat accounts for", $time);
          other_errors++;
        end else begin
          compare_beat(exp_q.pop_front());
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

/* image_stage_top.sv */
// Image input stage top: pipe, shift buffer and output slice in a chain
`timescale 1ns/1ps

module image_stage_top import image_pkg::*; (
  input  logic       aclk,
  input  logic       reset,
  input  logic       s1_valid,
  output logic       s1_ready,
  input  in_row_t    s1_data,
  input  logic       s1_last,
  input  logic       s2_valid,
  output logic       s2_ready,
  input  in_row_t    s2_data,
  input  logic       m_ready,
  output logic       m_valid,
  output pair_out_t  m_data,
  output pipe_user_t m_user
);

  logic       pipe_valid, pipe_ready;
  pair_row_t  pipe_data;
  pipe_user_t pipe_user;

  logic       buf_valid, buf_ready;
  pair_out_t  buf_data;
  pipe_user_t buf_user;

  axis_image_pipe pipe (
    .aclk       (aclk      ),
    .reset      (reset     ),
    .s1_valid   (s1_valid  ),
    .s1_ready   (s1_ready  ),
    .s1_data    (s1_data   ),
    .s1_last    (s1_last   ),
    .s2_valid   (s2_valid  ),
    .s2_ready   (s2_ready  ),
    .s2_data    (s2_data   ),
    .pipe_ready (pipe_ready),
    .pipe_valid (pipe_valid),
    .pipe_data  (pipe_data ),
    .pipe_user  (pipe_user )
  );

  image_shift_buffer shifter (
    .aclk       (aclk      ),
    .reset      (reset     ),
    .pipe_valid (pipe_valid),
    .pipe_ready (pipe_ready),
    .pipe_data  (pipe_data ),
    .pipe_user  (pipe_user ),
    .buf_ready  (buf_ready ),
    .buf_valid  (buf_valid ),
    .buf_data   (buf_data  ),
    .buf_user   (buf_user  )
  );

  axis_reg_slice slice (
    .aclk       (aclk      ),
    .reset      (reset     ),
    .buf_valid  (buf_valid ),
    .buf_ready  (buf_ready ),
    .buf_data   (buf_data  ),
    .buf_user   (buf_user  ),
    .m_ready    (m_ready   ),
    .m_valid    (m_valid   ),
    .m_data     (m_data    ),
    .m_user     (m_user    )
  );

endmodule

/* axis_reg_slice.sv */
// Two-entry register slice with a registered ready, placed at the shift buffer output
`timescale 1ns/1ps

module axis_reg_slice import image_pkg::*; (
  input  logic       aclk,
  input  logic       reset,
  input  logic       buf_valid,
  output logic       buf_ready,
  input  pair_out_t  buf_data,
  input  pipe_user_t buf_user,
  input  logic       m_ready,
  output logic       m_valid,
  output pair_out_t  m_data,
  output pipe_user_t m_user
);

  typedef struct packed {
    pair_out_t  data;
    pipe_user_t user;
  } entry_t;

  entry_t main_q, skid_q, in_entry;
  logic   skid_valid;
  logic   main_valid_d, skid_valid_d;
  logic   in_hs, main_free;

  assign in_entry  = '{data: buf_data, user: buf_user};
  assign in_hs     = buf_valid && buf_ready;
  assign main_free = m_ready || !m_valid;  // Main entry drains or is empty

  always_comb begin
    main_valid_d = m_valid;
    skid_valid_d = skid_valid;
    if (main_free) begin
      main_valid_d = skid_valid || in_hs;
      skid_valid_d = 1'b0;
    end else if (in_hs) begin
      skid_valid_d = 1'b1;  // Park the beat that arrived while main was stuck
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      buf_ready  <= 1'b0;
    end else begin
      m_valid    <= main_valid_d;
      skid_valid <= skid_valid_d;
      buf_ready  <= !skid_valid_d;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_free)
      main_q <= skid_valid ? skid_q : in_entry;
    else if (in_hs)
      skid_q <= in_entry;
  end

  assign m_data = main_q.data;
  assign m_user = main_q.user;

endmodule

/* image_shift_buffer.sv */
// Shift buffer that de-centers each padded beat and replays it kernel_h_1+1 times one word lower each time
`timescale 1ns/1ps

module image_shift_buffer import image_pkg::*; (
  input  logic       aclk,
  input  logic       reset,
  input  logic       pipe_valid,
  output logic       pipe_ready,
  input  pair_row_t  pipe_data,
  input  pipe_user_t pipe_user,
  input  logic       buf_ready,
  output logic       buf_valid,
  output pair_out_t  buf_data,
  output pipe_user_t buf_user
);

  logic [BITS_KERNEL_H-1:0] count, count_next;
  logic [BITS_KERNEL_H-1:0] h2_in;

  logic       valid_in;
  pipe_user_t user_in;

  in_row_t s_row [2];  // Index 0 is ch1, 1 is ch2
  in_row_t dec   [2];
  in_row_t sh_d  [2];
  in_row_t sh_q  [2];

  // The input is padded symmetrically but the shift runs one way only,
  // so smaller kernels start further up the row
  function automatic in_row_t decenter(
    input in_row_t                  row,
    input logic [BITS_KERNEL_H-1:0] h2
  );
    in_row_t d;
    d = '0;
    for (int i = 0; i < UNITS_EDGES; i++) begin
      if (i <= UNITS - 1 + 2 * h2)
        d[i] = row[i + KERNEL_H_MAX / 2 - h2];
    end
    return d;
  endfunction

  assign s_row[0] = pipe_data.ch1;
  assign s_row[1] = pipe_data.ch2;
  assign h2_in    = pipe_user.cfg.kernel_h_1 / 2;

  // Accept a new beat only when no repetition is pending
  always_comb begin
    if (count == 0) begin
      valid_in   = pipe_valid;
      user_in    = pipe_user;
      pipe_ready = buf_ready;
      count_next = pipe_user.is_config ? '0 : pipe_user.cfg.kernel_h_1;
    end else begin
      valid_in   = 1'b1;
      user_in    = buf_user;     // Same header on every repeat
      pipe_ready = 1'b0;
      count_next = count - 1'b1;
    end
  end

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      dec[c] = decenter(s_row[c], h2_in);
      if (count == 0)
        sh_d[c] = dec[c];
      else  // Each word takes its upper neighbour and the top word keeps D[top]
        sh_d[c] = {sh_q[c][UNITS_EDGES-1], sh_q[c][UNITS_EDGES-1:1]};
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      count     <= '0;
      buf_valid <= 1'b0;
    end else if (buf_ready) begin
      buf_valid <= valid_in;
      if (count != 0 || pipe_valid)
        count <= count_next;
    end
  end

  always_ff @(posedge aclk) begin
    if (buf_ready) begin
      sh_q     <= sh_d;
      buf_user <= user_in;
    end
  end

  assign buf_data.ch1 = sh_q[0][UNITS-1:0];  // Only the lower UNITS words leave
  assign buf_data.ch2 = sh_q[1][UNITS-1:0];

endmodule

/* axis_image_pipe.sv */
// Image pipe: takes the header from stream 1, sends the ones beats, then steers both streams to the buffer
`timescale 1ns/1ps

module axis_image_pipe import image_pkg::*; (
  input  logic       aclk,
  input  logic       reset,
  input  logic       s1_valid,
  output logic       s1_ready,
  input  in_row_t    s1_data,
  input  logic       s1_last,
  input  logic       s2_valid,
  output logic       s2_ready,
  input  in_row_t    s2_data,
  input  logic       pipe_ready,
  output logic       pipe_valid,
  output pair_row_t  pipe_data,
  output pipe_user_t pipe_user
);

  pipe_state_t state, state_next;
  image_cfg_t  cfg;
  logic [BITS_ONES_COUNT-1:0] ones_count;

  logic    s1_hs;
  logic    ones_done;
  in_row_t ones_row;

  assign s1_hs     = s1_valid && s1_ready;
  assign ones_done = (ones_count == ones_beats(cfg.kernel_h_1) - 1'b1) && pipe_ready;

  // Next state
  always_comb begin
    state_next = state;
    unique case (state)
      SET_S   : if (s1_hs) state_next = ONES_S;
      ONES_S  : if (ones_done) state_next = PASS_S;
      default : if (s1_hs && s1_last) state_next = SET_S;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      state      <= SET_S;
      cfg        <= '0;
      ones_count <= '0;
    end else begin
      state <= state_next;

      if (state == SET_S && s1_hs) begin  // Header words carry one flag each
        cfg.is_not_max <= s1_data[I_IS_NOT_MAX][0];
        cfg.is_max     <= s1_data[I_IS_MAX][0];
        cfg.is_lrelu   <= s1_data[I_IS_LRELU][0];
        cfg.kernel_h_1 <= s1_data[I_KERNEL_H_1][BITS_KERNEL_H-1:0];
      end

      if (state != ONES_S || ones_done)
        ones_count <= '0;
      else if (pipe_ready)
        ones_count <= ones_count + 1'b1;
    end
  end

  // Handshake steering
  always_comb begin
    unique case (state)
      SET_S : begin
        pipe_valid = 1'b0;
        s1_ready   = pipe_ready;
        s2_ready   = 1'b0;
      end
      ONES_S : begin
        pipe_valid = 1'b1;
        s1_ready   = 1'b0;
        s2_ready   = 1'b0;
      end
      default : begin
        if (cfg.is_max) begin  // Both streams move together
          pipe_valid = s1_valid && s2_valid;
          s1_ready   = pipe_ready && s2_valid;
          s2_ready   = pipe_ready && s1_valid;
        end else begin
          pipe_valid = s1_valid;
          s1_ready   = pipe_ready;
          s2_ready   = 1'b0;
        end
      end
    endcase
  end

  // Ones on the first KERNEL_H_MAX/2+1 words, zeros elsewhere to keep switching low
  always_comb begin
    for (int u = 0; u < UNITS_EDGES; u++) begin
      ones_row[u] = (u <= KERNEL_H_MAX / 2) ? WORD_WIDTH'(1) : '0;
    end
  end

  always_comb begin
    if (state == ONES_S) begin
      pipe_data.ch1 = ones_row;
      pipe_data.ch2 = ones_row;
    end else begin
      pipe_data.ch1 = s1_data;
      pipe_data.ch2 = cfg.is_max ? s2_data : s1_data;  // Shared channel when not max
    end
  end

  assign pipe_user.cfg       = cfg;
  assign pipe_user.is_config = (state == ONES_S);

endmodule

/* image_pkg.sv */
// Sizes, row and config types and the pipe FSM states, imported by the image stage and its testbench
package image_pkg;

  localparam int UNITS        = 4;                           // Output words per beat
  localparam int KERNEL_H_MAX = 3;                           // Largest odd kernel height
  localparam int UNITS_EDGES  = UNITS + KERNEL_H_MAX - 1;    // Padded input words
  localparam int WORD_WIDTH   = 8;

  localparam int BITS_KERNEL_H   = 2;
  localparam int BITS_ONES_COUNT = 2;

  // Word positions inside a config header beat
  localparam int I_IS_NOT_MAX = 0;
  localparam int I_IS_MAX     = 1;
  localparam int I_IS_LRELU   = 2;
  localparam int I_KERNEL_H_1 = 3;

  typedef logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] in_row_t;   // Word 0 in the low bits
  typedef logic [UNITS-1:0][WORD_WIDTH-1:0]       out_row_t;

  typedef struct packed {
    logic                     is_not_max;
    logic                     is_max;
    logic                     is_lrelu;
    logic [BITS_KERNEL_H-1:0] kernel_h_1;
  } image_cfg_t;

  // Travels beside the data through the whole stage
  typedef struct packed {
    image_cfg_t cfg;
    logic       is_config;  // High on the ones beats
  } pipe_user_t;

  typedef struct packed {
    in_row_t ch1;
    in_row_t ch2;
  } pair_row_t;

  typedef struct packed {
    out_row_t ch1;
    out_row_t ch2;
  } pair_out_t;

  typedef enum logic [1:0] {
    SET_S,   // Wait for the header beat
    ONES_S,  // Ones beats for the activation config
    PASS_S   // Image data
  } pipe_state_t;

  // Number of ones beats that follow a header
  function automatic logic [BITS_ONES_COUNT-1:0] ones_beats(
    input logic [BITS_KERNEL_H-1:0] kernel_h_1
  );
    return BITS_ONES_COUNT'(kernel_h_1 / 2 + 2);
  endfunction

endpackage
